//--- compile.f
hdl/load_pkg.sv
hdl/load_job_if.sv
hdl/load_sequencer.sv
hdl/line_requester.sv
hdl/prefetch_fifo.sv
hdl/region_fanout.sv
hdl/load_unit.sv
dv/tb_load_unit.sv

//--- dv/tb_load_unit.sv
`default_nettype none

module tb_load_unit import load_pkg::*; ();

    localparam int NUM_ROWS = 8;

    typedef struct packed
    {
        line_addr_t   base;
        word_t        base_offset;
        word_t        offset0;
        word_t        offset1;
        word_t        offset2;
        line_count_t  length;
        logic         multiline;
        logic         trigger;
        region_mask_t mask;
        region_mask_t af_regions;
        logic [2:0]   af_rate;
        line_addr_t   exp_addr;
    } row_t;

    logic         clk;
    logic         internal_reset;
    logic         op_start;
    logic         trigger_dma;
    logic         cfg_multiline;
    line_addr_t   base_addr;
    word_t        cfg_base_offset;
    word_t        cfg_offset [NUM_OFFSETS];
    line_count_t  cfg_length;
    region_mask_t cfg_region_mask;
    logic         op_done;
    logic         dma_idle;
    logic         dma_active;
    logic         dma_start;
    line_addr_t   dma_addr;
    line_count_t  dma_length;
    logic         dma_multiline;
    logic         rd_req;
    burst_len_t   rd_len;
    logic         rx_valid;
    line_t        rx_data;
    region_mask_t region_almostfull;
    region_mask_t region_we;
    line_t        region_wdata;

    row_t         rows [NUM_ROWS];
    row_t         cur;
    logic [31:0]  lcg_state;
    int           cycle_limit;
    int           cycles;
    int           ticks;
    int           errors;
    int           checks;
    int           failed_rows;

    // Per command bookkeeping
    bit           af_enable;
    int           done_count;
    int           done_tick;
    int           start_count;
    line_addr_t   seen_addr;
    line_count_t  seen_length;
    logic         seen_multiline;
    int           burst_log [$];
    int           burst_queue [$];
    int           burst_left;
    int           burst_gap;
    int           lines_returned;
    line_t        sent_lines [$];
    int           region_count [NUM_REGIONS];
    int           last_write_tick;

    // Almost-full values applied one and two ticks back
    region_mask_t af_prev1;
    region_mask_t af_prev2;

    load_unit uut
    (
        .clk,
        .internal_reset,
        .op_start,
        .trigger_dma,
        .cfg_multiline,
        .base_addr,
        .cfg_base_offset,
        .cfg_offset,
        .cfg_length,
        .cfg_region_mask,
        .op_done,
        .dma_idle,
        .dma_active,
        .dma_start,
        .dma_addr,
        .dma_length,
        .dma_multiline,
        .rd_req,
        .rd_len,
        .rx_valid,
        .rx_data,
        .region_almostfull,
        .region_we,
        .region_wdata
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: the commands did not complete within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // ********************************************************************
    // Helpers
    // ********************************************************************
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic line_t random_line();
        line_t value;
        for (int w = 0; w < LINE_WIDTH / 32; w++)
        begin
            value[w*32 +: 32] = next_random();
        end
        return value;
    endfunction

    // DMA engine burst code to line count
    function automatic int burst_lines(logic [1:0] code);
        case (code)
            2'd0:    return 1;
            2'd1:    return 2;
            2'd3:    return 4;
            default: return 0;
        endcase
    endfunction

    function automatic int rule_burst(int requested, int length, bit multiline);
        if (multiline && requested + 4 < length)
        begin
            return 4;
        end
        else if (multiline && requested + 2 < length)
        begin
            return 2;
        end
        else if (requested < length)
        begin
            return 1;
        end
        return 0;
    endfunction

    task automatic compare(input logic [LINE_WIDTH-1:0] actual,
                           input logic [LINE_WIDTH-1:0] expected,
                           input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic add_row(input int idx, input line_addr_t base, input word_t base_offset,
                           input word_t o0, input word_t o1, input word_t o2,
                           input line_count_t length, input logic multiline,
                           input logic trigger, input region_mask_t mask,
                           input region_mask_t af_regions, input logic [2:0] af_rate,
                           input line_addr_t exp_addr);
        rows[idx].base        = base;
        rows[idx].base_offset = base_offset;
        rows[idx].offset0     = o0;
        rows[idx].offset1     = o1;
        rows[idx].offset2     = o2;
        rows[idx].length      = length;
        rows[idx].multiline   = multiline;
        rows[idx].trigger     = trigger;
        rows[idx].mask        = mask;
        rows[idx].af_regions  = af_regions;
        rows[idx].af_rate     = af_rate;
        rows[idx].exp_addr    = exp_addr;
    endtask

    // ********************************************************************
    // Command table
    // ********************************************************************
    task automatic build_table();
        // Single lines into one region
        add_row(0, 64'h0000_1234_0000_0100, 32'h10, 32'h1, 32'h2, 32'h3,
                5, 1'b0, 1'b1, 6'b000001, 6'b000000, 3'b111, 64'h0000_1234_0000_0116);
        // Low half wraps twice
        add_row(1, 64'hdead_beef_ffff_fff0, 32'h20, 32'hffff_fff0, 32'h5, 32'h7,
                13, 1'b1, 1'b1, 6'b101101, 6'b000000, 3'b111, 64'hdead_beef_0000_000c);
        add_row(2, 64'h0000_0000_0000_1000, 32'h0, 32'h0, 32'h0, 32'h0,
                0, 1'b1, 1'b1, 6'b111111, 6'b000000, 3'b111, 64'h0000_0000_0000_1000);
        // Engine already running without a trigger
        add_row(3, 64'h0000_0001_0000_0200, 32'h4, 32'h8, 32'hc, 32'h10,
                6, 1'b1, 1'b0, 6'b010010, 6'b000000, 3'b111, 64'h0000_0001_0000_0228);
        // Heavy holds on a job short enough for the FIFO
        add_row(4, 64'h0000_0042_8000_0000, 32'h4000_0000, 32'h4000_0000, 32'h1, 32'h2,
                12, 1'b1, 1'b1, 6'b001111, 6'b000101, 3'b001, 64'h0000_0042_0000_0003);
        add_row(5, 64'h1111_2222_3333_4444, 32'h100, 32'h10, 32'h20, 32'h30,
                40, 1'b1, 1'b1, 6'b111111, 6'b111111, 3'b111, 64'h1111_2222_3333_45a4);
        // Disabled regions held almost full for the whole command
        add_row(6, 64'h0000_0000_0000_0000, 32'h8, 32'ha, 32'hb, 32'hc,
                9, 1'b1, 1'b1, 6'b000011, 6'b111100, 3'b000, 64'h0000_0000_0000_0029);
        add_row(7, 64'h0000_0005_0000_0000, 32'h0, 32'h0, 32'h0, 32'h0,
                0, 1'b0, 1'b0, 6'b000111, 6'b000000, 3'b111, 64'h0000_0005_0000_0000);
    endtask

    // ********************************************************************
    // DMA engine and region models
    // ********************************************************************
    task automatic observe_outputs();
        int lines;
        if (op_done === 1'b1)
        begin
            done_count++;
            done_tick = ticks;
        end
        if (dma_start === 1'b1)
        begin
            start_count++;
            seen_addr      = dma_addr;
            seen_length    = dma_length;
            seen_multiline = dma_multiline;
            dma_active     = 1'b1;
            dma_idle       = 1'b0;
        end
        if (rd_req === 1'b1)
        begin
            lines = burst_lines(rd_len);
            burst_log.push_back(lines);
            burst_queue.push_back(lines);
        end
        // A hold seen three ticks back must have stopped the read behind this write
        if (region_we !== '0)
        begin
            compare((af_prev2 & cur.mask) == '0, 1'b1, "region write while almost full");
        end
        for (int r = 0; r < NUM_REGIONS; r++)
        begin
            if (region_we[r] === 1'b1)
            begin
                compare(cur.mask[r], 1'b1, $sformatf("write to disabled region %0d", r));
                compare(region_count[r] < sent_lines.size(), 1'b1,
                        $sformatf("region %0d written beyond returned lines", r));
                if (region_count[r] < sent_lines.size())
                begin
                    compare(region_wdata, sent_lines[region_count[r]],
                            $sformatf("region %0d line %0d data", r, region_count[r]));
                end
                region_count[r]++;
                last_write_tick = ticks;
            end
        end
        af_prev2 = af_prev1;
        af_prev1 = region_almostfull;
    endtask

    task automatic drive_models();
        rx_valid = 1'b0;
        if (burst_left == 0 && burst_queue.size() > 0)
        begin
            burst_left = burst_queue.pop_front();
            burst_gap  = int'(next_random() & 32'd3);
        end
        if (burst_gap > 0)
        begin
            burst_gap--;
        end
        else if (burst_left > 0)
        begin
            rx_valid = 1'b1;
            rx_data  = random_line();
            sent_lines.push_back(rx_data);
            burst_left--;
            lines_returned++;
        end
        if (dma_active && lines_returned == int'(cur.length))
        begin
            dma_active = 1'b0;
            dma_idle   = 1'b1;
        end
        region_almostfull = '0;
        if (af_enable && cur.af_regions != '0 && (next_random() & cur.af_rate) == 0)
        begin
            region_almostfull = cur.af_regions;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        ticks++;
        observe_outputs();
        drive_models();
    endtask

    // ********************************************************************
    // One command
    // ********************************************************************
    task automatic run_row(input int idx);
        int row_errors;
        int start_tick;
        int requested;
        int expected;
        cur             = rows[idx];
        row_errors      = errors;
        done_count      = 0;
        done_tick       = 0;
        start_count     = 0;
        burst_left      = 0;
        burst_gap       = 0;
        lines_returned  = 0;
        last_write_tick = 0;
        burst_log.delete();
        burst_queue.delete();
        sent_lines.delete();
        for (int r = 0; r < NUM_REGIONS; r++)
        begin
            region_count[r] = 0;
        end

        tick();
        op_start        = 1'b1;
        trigger_dma     = cur.trigger;
        cfg_multiline   = cur.multiline;
        base_addr       = cur.base;
        cfg_base_offset = cur.base_offset;
        cfg_offset[0]   = cur.offset0;
        cfg_offset[1]   = cur.offset1;
        cfg_offset[2]   = cur.offset2;
        cfg_length      = cur.length;
        cfg_region_mask = cur.mask;
        start_tick      = ticks;
        af_enable       = 1'b1;
        if (!cur.trigger && cur.length != 0)
        begin
            dma_active = 1'b1;
            dma_idle   = 1'b0;
        end
        while (done_count == 0)
        begin
            tick();
            op_start = 1'b0;
        end
        af_enable         = 1'b0;
        region_almostfull = '0;
        repeat (3) tick();

        compare(done_count, 1, "op_done pulses");
        if (cur.length == 0)
        begin
            compare(done_tick - start_tick, 2, "op_done latency for zero length");
        end
        else
        begin
            compare(done_tick > last_write_tick, 1'b1, "op_done after last region write");
        end
        if (cur.trigger && cur.length != 0)
        begin
            compare(start_count, 1, "dma_start pulses");
            compare(seen_addr, cur.exp_addr, "dma_addr");
            compare(seen_length, cur.length, "dma_length");
            compare(seen_multiline, cur.multiline, "dma_multiline");
        end
        else
        begin
            compare(start_count, 0, "dma_start pulses");
        end

        requested = 0;
        for (int i = 0; i < burst_log.size(); i++)
        begin
            expected = rule_burst(requested, int'(cur.length), cur.multiline);
            compare(burst_log[i], expected, $sformatf("burst %0d lines", i));
            requested += burst_log[i];
        end
        compare(requested, cur.length, "lines requested");
        compare(sent_lines.size(), cur.length, "lines returned by DMA model");
        for (int r = 0; r < NUM_REGIONS; r++)
        begin
            expected = cur.mask[r] ? int'(cur.length) : 0;
            compare(region_count[r], expected, $sformatf("region %0d write count", r));
        end

        if (errors != row_errors)
        begin
            failed_rows++;
        end
        $display("row %0d: length %0d, multiline %0b, trigger %0b, mask %b: %s",
                 idx, cur.length, cur.multiline, cur.trigger, cur.mask,
                 (errors == row_errors) ? "ok" : "FAILED");
    endtask

    initial
    begin
        clk               = 1'b0;
        internal_reset    = 1'b1;
        op_start          = 1'b0;
        trigger_dma       = 1'b0;
        cfg_multiline     = 1'b0;
        base_addr         = '0;
        cfg_base_offset   = '0;
        cfg_offset[0]     = '0;
        cfg_offset[1]     = '0;
        cfg_offset[2]     = '0;
        cfg_length        = '0;
        cfg_region_mask   = '0;
        dma_idle          = 1'b1;
        dma_active        = 1'b0;
        rx_valid          = 1'b0;
        rx_data           = '0;
        region_almostfull = '0;
        lcg_state         = 32'h97a;
        cycles            = 0;
        ticks             = 0;
        errors            = 0;
        checks            = 0;
        failed_rows       = 0;
        af_enable         = 1'b0;
        af_prev1          = '0;
        af_prev2          = '0;
        cur               = '0;

        build_table();
        cycle_limit = 0;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            cycle_limit += int'(rows[i].length) * 8 + 50;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        internal_reset = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            run_row(i);
        end

        $display("%0d rows, %0d failed, %0d checks, %0d errors",
                 NUM_ROWS, failed_rows, checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/line_requester.sv
`default_nettype none

module line_requester import load_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        internal_reset,

    load_job_if.requester    job,

    input  wire logic        dma_active,
    output logic             rd_req,
    output burst_len_t       rd_len,
    input  wire logic        rx_valid,
    input  wire line_t       rx_data,

    input  wire logic        reading,
    input  wire fifo_count_t fifo_count,
    output logic             fifo_we,
    output line_t            fifo_wdata
);

    line_count_t requested;
    line_count_t received;
    line_count_t requested_plus2;
    line_count_t requested_plus4;

    credit_t in_flight;
    credit_t free_space;
    credit_t allowance;

    assign requested_plus2 = requested + line_count_t'(2);
    assign requested_plus4 = requested + line_count_t'(4);

    // ********************************************************************
    // Credit pipeline, two cycles behind the counters
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        in_flight  <= credit_t'(requested - received);
        free_space <= credit_t'(PREFETCH_DEPTH) - credit_t'(fifo_count);
        allowance  <= free_space - in_flight;
    end

    // ********************************************************************
    // Burst selection
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            requested <= '0;
            received  <= '0;
            rd_req    <= 1'b0;
            fifo_we   <= 1'b0;
        end
        else
        begin
            rd_req  <= 1'b0;
            fifo_we <= reading && rx_valid;
            if (job.go)
            begin
                requested <= '0;
                received  <= '0;
            end
            else
            begin
                if (reading && rx_valid)
                begin
                    received <= received + 1'b1;
                end
                if (reading && dma_active && allowance > 0)
                begin
                    if (job.multiline && requested_plus4 < job.length)
                    begin
                        rd_req    <= 1'b1;
                        rd_len    <= BURST_4;
                        requested <= requested_plus4;
                    end
                    else if (job.multiline && requested_plus2 < job.length)
                    begin
                        rd_req    <= 1'b1;
                        rd_len    <= BURST_2;
                        requested <= requested_plus2;
                    end
                    else if (requested < job.length)
                    begin
                        rd_req    <= 1'b1;
                        rd_len    <= BURST_1;
                        requested <= requested + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        fifo_wdata <= rx_data;
    end

endmodule

`default_nettype wire

//--- hdl/load_job_if.sv
`default_nettype none

interface load_job_if import load_pkg::*; ();

    // Job start, marks entry to READ
    logic         go;
    line_count_t  length;
    logic         multiline;
    region_mask_t region_mask;
    // One pulse per broadcast line
    logic         forwarded;

    modport sequencer
    (
        output go,
        output length,
        output multiline,
        output region_mask,
        input  forwarded
    );

    modport requester
    (
        input go,
        input length,
        input multiline
    );

    modport fanout
    (
        input  region_mask,
        output forwarded
    );

endinterface

`default_nettype wire

//--- hdl/load_pkg.sv
`default_nettype none

package load_pkg;

    // ********************************************************************
    // Sizes
    // ********************************************************************
    localparam int LINE_WIDTH          = 512;
    localparam int LINE_ADDR_WIDTH     = 64;
    localparam int WORD_WIDTH          = 32;
    localparam int LINE_COUNT_WIDTH    = 32;
    localparam int CREDIT_WIDTH        = 32;
    localparam int NUM_OFFSETS         = 3;
    localparam int LOG2_PREFETCH_DEPTH = 4;
    localparam int PREFETCH_DEPTH      = 1 << LOG2_PREFETCH_DEPTH;
    localparam int NUM_REGIONS         = 6;

    // ********************************************************************
    // Vector types
    // ********************************************************************
    typedef logic [LINE_WIDTH-1:0]          line_t;
    typedef logic [LINE_ADDR_WIDTH-1:0]     line_addr_t;
    typedef logic [WORD_WIDTH-1:0]          word_t;
    typedef logic [LINE_COUNT_WIDTH-1:0]    line_count_t;
    typedef logic signed [CREDIT_WIDTH-1:0] credit_t;
    typedef logic [LOG2_PREFETCH_DEPTH:0]   fifo_count_t;
    typedef logic [NUM_REGIONS-1:0]         region_mask_t;

    // ********************************************************************
    // Enums
    // ********************************************************************

    // Encoding as expected by the DMA read engine
    typedef enum logic [1:0]
    {
        BURST_1 = 2'd0,
        BURST_2 = 2'd1,
        BURST_4 = 2'd3
    } burst_len_t;

    typedef enum logic [2:0]
    {
        IDLE,
        PREPROCESS,
        DMA_TRIGGER,
        WRITE_TRIGGER,
        READ,
        DONE
    } load_state_t;

endpackage

`default_nettype wire

//--- hdl/load_sequencer.sv
`default_nettype none

module load_sequencer import load_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       internal_reset,

    input  wire logic       op_start,
    input  wire logic       trigger_dma,
    input  wire logic       cfg_multiline,
    input  wire line_addr_t base_addr,
    input  wire word_t      cfg_base_offset,
    input  wire word_t      cfg_offset [NUM_OFFSETS],
    input  wire line_count_t cfg_length,
    input  wire region_mask_t cfg_region_mask,

    input  wire logic       dma_idle,
    output logic            dma_start,
    output line_addr_t      dma_addr,
    output line_count_t     dma_length,
    output logic            dma_multiline,

    output logic            reading,
    output logic            op_done,

    load_job_if.sequencer   job
);

    load_state_t state;

    logic                           use_dma;
    word_t                          offset_r [NUM_OFFSETS];
    word_t                          addr_high;
    word_t                          running_offset;
    logic [$clog2(NUM_OFFSETS)-1:0] offset_idx;
    line_count_t                    fwd_count;
    line_count_t                    fwd_next;

    assign reading = (state == READ);

    always_comb
    begin
        fwd_next = fwd_count + line_count_t'(job.forwarded);
    end

    // ********************************************************************
    // Command capture and address build
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (state == IDLE && op_start)
        begin
            use_dma         <= trigger_dma;
            offset_r        <= cfg_offset;
            addr_high       <= base_addr[LINE_ADDR_WIDTH-1:WORD_WIDTH];
            running_offset  <= base_addr[WORD_WIDTH-1:0] + cfg_base_offset;
            job.length      <= cfg_length;
            job.multiline   <= cfg_multiline;
            job.region_mask <= cfg_region_mask;
            offset_idx      <= '0;
        end
        if (state == PREPROCESS)
        begin
            running_offset <= running_offset + offset_r[offset_idx];
            offset_idx     <= offset_idx + 1'b1;
        end
        if (state == DMA_TRIGGER && dma_idle)
        begin
            dma_addr      <= {addr_high, running_offset};
            dma_length    <= job.length;
            dma_multiline <= job.multiline;
        end
    end

    // ********************************************************************
    // Job FSM
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            state     <= IDLE;
            dma_start <= 1'b0;
            op_done   <= 1'b0;
            job.go    <= 1'b0;
            fwd_count <= '0;
        end
        else
        begin
            dma_start <= 1'b0;
            op_done   <= 1'b0;
            job.go    <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (op_start)
                    begin
                        fwd_count <= '0;
                        state     <= (cfg_length == '0) ? DONE : PREPROCESS;
                    end
                end
                PREPROCESS:
                begin
                    if (offset_idx == NUM_OFFSETS - 1)
                    begin
                        state <= use_dma ? DMA_TRIGGER : WRITE_TRIGGER;
                    end
                end
                DMA_TRIGGER:
                begin
                    if (dma_idle)
                    begin
                        dma_start <= 1'b1;
                        state     <= WRITE_TRIGGER;
                    end
                end
                WRITE_TRIGGER:
                begin
                    job.go <= 1'b1;
                    state  <= READ;
                end
                READ:
                begin
                    fwd_count <= fwd_next;
                    if (fwd_next == job.length)
                    begin
                        state <= DONE;
                    end
                end
                DONE:
                begin
                    op_done <= 1'b1;
                    state   <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/load_unit.sv
`default_nettype none

module load_unit import load_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         internal_reset,

    input  wire logic         op_start,
    input  wire logic         trigger_dma,
    input  wire logic         cfg_multiline,
    input  wire line_addr_t   base_addr,
    input  wire word_t        cfg_base_offset,
    input  wire word_t        cfg_offset [NUM_OFFSETS],
    input  wire line_count_t  cfg_length,
    input  wire region_mask_t cfg_region_mask,
    output logic              op_done,

    input  wire logic         dma_idle,
    input  wire logic         dma_active,
    output logic              dma_start,
    output line_addr_t        dma_addr,
    output line_count_t       dma_length,
    output logic              dma_multiline,
    output logic              rd_req,
    output burst_len_t        rd_len,
    input  wire logic         rx_valid,
    input  wire line_t        rx_data,

    input  wire region_mask_t region_almostfull,
    output region_mask_t      region_we,
    output line_t             region_wdata
);

    logic        reading;
    logic        fifo_we;
    line_t       fifo_wdata;
    logic        fifo_re;
    logic        fifo_rvalid;
    line_t       fifo_rdata;
    logic        fifo_empty;
    fifo_count_t fifo_count;

    load_job_if job ();

    load_sequencer u_sequencer
    (
        .clk,
        .internal_reset,
        .op_start,
        .trigger_dma,
        .cfg_multiline,
        .base_addr,
        .cfg_base_offset,
        .cfg_offset,
        .cfg_length,
        .cfg_region_mask,
        .dma_idle,
        .dma_start,
        .dma_addr,
        .dma_length,
        .dma_multiline,
        .reading,
        .op_done,
        .job       (job.sequencer)
    );

    line_requester u_requester
    (
        .clk,
        .internal_reset,
        .job       (job.requester),
        .dma_active,
        .rd_req,
        .rd_len,
        .rx_valid,
        .rx_data,
        .reading,
        .fifo_count,
        .fifo_we,
        .fifo_wdata
    );

    prefetch_fifo u_prefetch_fifo
    (
        .clk,
        .internal_reset,
        .we        (fifo_we),
        .wdata     (fifo_wdata),
        .re        (fifo_re),
        .rvalid    (fifo_rvalid),
        .rdata     (fifo_rdata),
        .empty     (fifo_empty),
        .count     (fifo_count)
    );

    region_fanout u_fanout
    (
        .clk,
        .internal_reset,
        .job       (job.fanout),
        .fifo_empty,
        .fifo_re,
        .fifo_rvalid,
        .fifo_rdata,
        .region_almostfull,
        .region_we,
        .region_wdata
    );

endmodule

`default_nettype wire

//--- hdl/prefetch_fifo.sv
`default_nettype none

module prefetch_fifo import load_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  internal_reset,

    input  wire logic  we,
    input  wire line_t wdata,
    input  wire logic  re,
    output logic       rvalid,
    output line_t      rdata,
    output logic       empty,
    output fifo_count_t count
);

    line_t mem [PREFETCH_DEPTH];

    logic [LOG2_PREFETCH_DEPTH-1:0] wr_ptr;
    logic [LOG2_PREFETCH_DEPTH-1:0] rd_ptr;
    logic                           full;
    logic                           wr_en;
    logic                           rd_en;

    assign empty = (count == '0);
    assign full  = (count == fifo_count_t'(PREFETCH_DEPTH));
    assign wr_en = we && !full;
    assign rd_en = re && !empty;

    // Storage and registered read port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wdata;
        end
        if (rd_en)
        begin
            rdata <= mem[rd_ptr];
        end
    end

    // ********************************************************************
    // Pointers and fill count
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= rd_en;
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/region_fanout.sv
`default_nettype none

module region_fanout import load_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         internal_reset,

    load_job_if.fanout        job,

    input  wire logic         fifo_empty,
    output logic              fifo_re,
    input  wire logic         fifo_rvalid,
    input  wire line_t        fifo_rdata,

    input  wire region_mask_t region_almostfull,
    output region_mask_t      region_we,
    output line_t             region_wdata
);

    // Disabled regions never hold back the stream
    logic hold;

    assign fifo_re = !fifo_empty && !hold;

    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            hold          <= 1'b0;
            region_we     <= '0;
            job.forwarded <= 1'b0;
        end
        else
        begin
            hold          <= |(region_almostfull & job.region_mask);
            region_we     <= fifo_rvalid ? job.region_mask : '0;
            job.forwarded <= fifo_rvalid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fifo_rvalid)
        begin
            region_wdata <= fifo_rdata;
        end
    end

endmodule

`default_nettype wire
